/* elevator.f */
+incdir+sim
logic/elevator_pkg.sv
logic/call_intake.sv
logic/stop_placer.sv
logic/stop_queue.sv
logic/car_control.sv
logic/elevator_top.sv
sim/elevator_tb.sv

/* logic/call_intake.sv */
module call_intake (
    input  logic                 clk,
    input  logic                 clear,
    input  elevator_pkg::call_t  call,
    input  logic                 call_strobe,
    input  elevator_pkg::floor_t car_floor,
    output logic                 ready,
    output elevator_pkg::stop_t  new_stop
);
    import elevator_pkg::*;

    call_t held;      // call being split into stops
    logic  take;
    logic  drop_due;

    // busy while a stop is going out
    assign ready    = !new_stop.valid;
    assign take     = call_strobe && ready;
    assign drop_due = new_stop.valid && new_stop.is_pickup;  // pickup out, drop-off next

    always_ff @(posedge clk) begin
        if (take) held <= call;
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            new_stop <= '0;
        end else if (drop_due) begin
            new_stop <= '{valid: 1'b1, is_pickup: 1'b0, kind: held.kind,
                          floor: held.destination};
        end else if (take) begin
            if (call.origin == call.destination) begin
                // nothing to carry, one stop at the floor
                new_stop <= '{valid: 1'b1, is_pickup: 1'b0, kind: call.kind,
                              floor: call.destination};
            end else begin
                new_stop <= '{valid: 1'b1, is_pickup: 1'b1, kind: call.kind,
                              floor: call.origin};
            end
        end else begin
            new_stop <= '0;
        end
    end

endmodule

/* logic/car_control.sv */
module car_control (
    input  logic                 clk,
    input  logic                 clear,
    input  elevator_pkg::stop_t  head,
    input  elevator_pkg::count_t count,
    output logic                 pop,
    output elevator_pkg::floor_t car_floor,
    output logic                 moving_up,
    output logic                 moving_down,
    output logic                 door_open,
    output elevator_pkg::stop_t  served,
    output logic                 served_strobe
);
    import elevator_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        TRAVEL,
        DOOR
    } state_t;

    state_t state;
    timer_t timer;       // shared by floor travel and door hold
    logic   going_up;
    logic   have_stop;
    logic   at_head;
    floor_t next_floor;

    assign have_stop  = count != '0;
    assign at_head    = have_stop && (head.floor == car_floor);
    assign next_floor = going_up ? car_floor + 1'b1 : car_floor - 1'b1;

    assign pop         = (state == DOOR) && (timer == '0);  // last open cycle
    assign door_open   = state == DOOR;
    assign moving_up   = (state == TRAVEL) && going_up;
    assign moving_down = (state == TRAVEL) && !going_up;

    always_ff @(posedge clk) begin
        if (state == IDLE && at_head) served <= head;
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state         <= IDLE;
            timer         <= '0;
            going_up      <= 1'b0;
            car_floor     <= '0;
            served_strobe <= 1'b0;
        end else begin
            served_strobe <= 1'b0;
            case (state)
                IDLE: begin
                    if (at_head) begin
                        state         <= DOOR;
                        timer         <= timer_t'(DOOR_CYCLES - 1);
                        served_strobe <= 1'b1;
                    end else if (have_stop) begin
                        state    <= TRAVEL;
                        timer    <= timer_t'(MOVE_CYCLES - 1);
                        going_up <= head.floor > car_floor;
                    end
                end
                TRAVEL: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        // arrived at the next floor, look at the head again
                        car_floor <= next_floor;
                        timer     <= timer_t'(MOVE_CYCLES - 1);
                        if (!have_stop || (head.floor == next_floor)) begin
                            state <= IDLE;
                        end else begin
                            going_up <= head.floor > next_floor;
                        end
                    end
                end
                DOOR: begin
                    if (timer != '0) timer <= timer - 1'b1;
                    else state <= IDLE;  // head popped on this edge
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/elevator_pkg.sv */
package elevator_pkg;

    // sizes and delays
    localparam int QUEUE_DEPTH = 16;
    localparam int MOVE_CYCLES = 16;  // clocks per floor of travel
    localparam int DOOR_CYCLES = 8;   // clocks the door stays open
    localparam int TIMER_WIDTH =
        $clog2((MOVE_CYCLES > DOOR_CYCLES) ? MOVE_CYCLES : DOOR_CYCLES);

    typedef logic [1:0] floor_t;
    typedef logic [3:0] slot_t;
    typedef logic [4:0] count_t;  // 0 to QUEUE_DEPTH
    typedef logic [TIMER_WIDTH-1:0] timer_t;

    typedef enum logic [1:0] {
        LOAD_PASSENGER,
        LOAD_CARGO,
        LOAD_SERVICE,
        LOAD_PRIORITY
    } load_kind_t;

    typedef struct packed {
        floor_t     origin;
        floor_t     destination;
        load_kind_t kind;
    } call_t;

    typedef struct packed {
        logic       valid;
        logic       is_pickup;
        load_kind_t kind;
        floor_t     floor;
    } stop_t;

    typedef stop_t [QUEUE_DEPTH-1:0] stop_list_t;

    // next contents of the stop list, pop first, then insert
    function automatic stop_list_t list_update(stop_list_t list, logic pop, logic ins,
                                               slot_t slot, stop_t stop);
        stop_list_t shifted;
        stop_list_t result;
        slot_t      at;
        shifted = list;
        at      = slot;
        if (pop) begin
            shifted = {stop_t'('0), list[QUEUE_DEPTH-1:1]};
            if (slot != '0) at = slot - 1'b1;  // the stop ahead is gone
        end
        result = shifted;
        if (ins) begin
            for (int i = 1; i < QUEUE_DEPTH; i++) begin
                if (slot_t'(i) > at) result[i] = shifted[i-1];
            end
            result[at] = stop;
        end
        return result;
    endfunction

    function automatic count_t count_update(count_t count, logic pop, logic ins);
        logic pop_live;
        pop_live = pop && (count != '0);
        return count + count_t'(ins) - count_t'(pop_live);
    endfunction

endpackage

/* logic/elevator_top.sv */
module elevator_top (
    input  logic                 clk,
    input  logic                 clear,
    input  elevator_pkg::call_t  call,
    input  logic                 call_strobe,
    output logic                 ready,
    output elevator_pkg::floor_t floor,
    output logic                 moving_up,
    output logic                 moving_down,
    output logic                 door_open,
    output elevator_pkg::stop_t  served,
    output logic                 served_strobe,
    output logic                 dropped_strobe
);
    import elevator_pkg::*;

    stop_t      new_stop;
    stop_t      ins_stop;
    logic       ins_strobe;
    slot_t      ins_slot;
    stop_list_t stops;
    count_t     count;
    logic       pop;

    call_intake u_intake (
        .clk         (clk),
        .clear       (clear),
        .call        (call),
        .call_strobe (call_strobe),
        .car_floor   (floor),
        .ready       (ready),
        .new_stop    (new_stop)
    );

    stop_placer u_placer (
        .clk            (clk),
        .clear          (clear),
        .new_stop       (new_stop),
        .stops          (stops),
        .count          (count),
        .car_floor      (floor),
        .pop            (pop),
        .ins_stop       (ins_stop),
        .ins_strobe     (ins_strobe),
        .ins_slot       (ins_slot),
        .dropped_strobe (dropped_strobe)
    );

    stop_queue u_queue (
        .clk        (clk),
        .clear      (clear),
        .ins_stop   (ins_stop),
        .ins_strobe (ins_strobe),
        .ins_slot   (ins_slot),
        .pop        (pop),
        .stops      (stops),
        .count      (count)
    );

    // the car only ever looks at the head of the list
    car_control u_car (
        .clk           (clk),
        .clear         (clear),
        .head          (stops[0]),
        .count         (count),
        .pop           (pop),
        .car_floor     (floor),
        .moving_up     (moving_up),
        .moving_down   (moving_down),
        .door_open     (door_open),
        .served        (served),
        .served_strobe (served_strobe)
    );

endmodule

/* logic/stop_placer.sv */
module stop_placer (
    input  logic                     clk,
    input  logic                     clear,
    input  elevator_pkg::stop_t      new_stop,
    input  elevator_pkg::stop_list_t stops,
    input  elevator_pkg::count_t     count,
    input  elevator_pkg::floor_t     car_floor,
    input  logic                     pop,
    output elevator_pkg::stop_t      ins_stop,
    output logic                     ins_strobe,
    output elevator_pkg::slot_t      ins_slot,
    output logic                     dropped_strobe
);
    import elevator_pkg::*;

    stop_list_t view;        // list as it stands after this edge
    count_t     view_count;
    slot_t      pick_at;     // where the pickup in flight lands
    count_t     start;       // first index the search may use
    count_t     place;
    logic       found;
    logic       full;
    logic       pick_dropped;
    logic       follows_pick;
    floor_t     below [QUEUE_DEPTH];

    function automatic logic between(floor_t a, floor_t f, floor_t b);
        return ((a < f) && (f < b)) || ((b < f) && (f < a));
    endfunction

    // fold in the pop and our own insert that land on this edge
    assign view       = list_update(stops, pop, ins_strobe, ins_slot, ins_stop);
    assign view_count = count_update(count, pop, ins_strobe);
    assign full       = view_count >= count_t'(QUEUE_DEPTH);

    assign pick_at      = (pop && (ins_slot != '0)) ? ins_slot - 1'b1 : ins_slot;
    assign follows_pick = !new_stop.is_pickup && ins_strobe && ins_stop.is_pickup;
    assign start        = follows_pick ? count_t'(pick_at) + count_t'(1) : '0;

    always_comb begin
        below[0] = car_floor;  // floor(-1) is where the car is
        for (int i = 1; i < QUEUE_DEPTH; i++) begin
            below[i] = view[i-1].floor;
        end
    end

    // first gap whose floors straddle the new stop, else the tail
    always_comb begin
        found = 1'b0;
        place = view_count;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (!found && (count_t'(i) >= start) && (count_t'(i) < view_count) &&
                between(below[i], new_stop.floor, view[i].floor)) begin
                found = 1'b1;
                place = count_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_stop.valid) begin
            ins_stop <= new_stop;
            ins_slot <= slot_t'(place);
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            ins_strobe     <= 1'b0;
            dropped_strobe <= 1'b0;
            pick_dropped   <= 1'b0;
        end else begin
            ins_strobe     <= 1'b0;
            dropped_strobe <= 1'b0;
            if (new_stop.valid) begin
                if (full || (!new_stop.is_pickup && pick_dropped)) begin
                    dropped_strobe <= 1'b1;
                    pick_dropped   <= new_stop.is_pickup;  // its drop-off goes too
                end else begin
                    ins_strobe   <= 1'b1;
                    pick_dropped <= 1'b0;
                end
            end
        end
    end

endmodule

/* logic/stop_queue.sv */
module stop_queue (
    input  logic                     clk,
    input  logic                     clear,
    input  elevator_pkg::stop_t      ins_stop,
    input  logic                     ins_strobe,
    input  elevator_pkg::slot_t      ins_slot,
    input  logic                     pop,
    output elevator_pkg::stop_list_t stops,
    output elevator_pkg::count_t     count
);
    import elevator_pkg::*;

    stop_list_t stops_next;
    count_t     count_next;

    // entry 0 is the head the car is working on
    // insert shifts the tail back, insert at count is a plain append
    // pop moves all entries forward and leaves the last one empty
    assign stops_next = list_update(stops, pop, ins_strobe, ins_slot, ins_stop);
    assign count_next = count_update(count, pop, ins_strobe);

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            stops <= '0;  // all valid bits low
            count <= '0;
        end else begin
            if (pop || ins_strobe) begin
                stops <= stops_next;
                count <= count_next;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the elevator testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module elevator_tb -f elevator.f -o elevator_sim

status=0
output=$(./obj_dir/elevator_sim 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1

/* sim/elevator_model.svh */
`ifndef ELEVATOR_MODEL_SVH
`define ELEVATOR_MODEL_SVH

// model of the stop list, filled in call order while the car holds its floor
stop_t  model_list[$];
floor_t model_car_floor;   // floor the placement rule starts from
int     model_drops;
int     model_pick_at;     // index of the last pickup placed
logic   model_pick_lost;   // last pickup was thrown away
stop_t  expected_q[$];     // stops in the order the car must serve them

// first index from first_idx on whose neighbours straddle floor f, else the tail
function automatic int find_slot(floor_t f, int first_idx);
    int lower;
    int upper;
    for (int i = first_idx; i < model_list.size(); i++) begin
        lower = (i == 0) ? int'(model_car_floor) : int'(model_list[i-1].floor);
        upper = int'(model_list[i].floor);
        if ((int'(f) - lower) * (upper - int'(f)) > 0) return i;  // strictly inside
    end
    return model_list.size();
endfunction

function automatic void insert_stop(stop_t s, logic after_pick);
    int at;
    if (model_list.size() >= QUEUE_DEPTH || (after_pick && model_pick_lost)) begin
        model_drops++;
        model_pick_lost = s.is_pickup;
    end else begin
        // a drop-off never goes ahead of its own pickup
        at = after_pick ? find_slot(s.floor, model_pick_at + 1) : find_slot(s.floor, 0);
        model_list.insert(at, s);
        if (s.is_pickup) model_pick_at = at;
        model_pick_lost = 1'b0;
    end
endfunction

function automatic void split_call(call_t c);
    stop_t s;
    if (c.origin == c.destination) begin
        s = '{valid: 1'b1, is_pickup: 1'b0, kind: c.kind, floor: c.destination};
        insert_stop(s, 1'b0);
    end else begin
        s = '{valid: 1'b1, is_pickup: 1'b1, kind: c.kind, floor: c.origin};
        insert_stop(s, 1'b0);
        s = '{valid: 1'b1, is_pickup: 1'b0, kind: c.kind, floor: c.destination};
        insert_stop(s, 1'b1);
    end
endfunction

// head first, so the car serves the list as it stands
function automatic void service_order();
    foreach (model_list[i]) expected_q.push_back(model_list[i]);
    if (model_list.size() != 0) model_car_floor = model_list[model_list.size()-1].floor;
    model_list.delete();
endfunction

function automatic void reset_model();
    model_list.delete();
    model_car_floor = '0;
    model_pick_at   = 0;
    model_pick_lost = 1'b0;
endfunction

`endif

/* sim/elevator_tb.sv */
module elevator_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import elevator_pkg::*;

    logic   clk;
    logic   clear;
    call_t  call;
    logic   call_strobe;
    logic   ready;
    floor_t floor;
    logic   moving_up;
    logic   moving_down;
    logic   door_open;
    stop_t  served;
    logic   served_strobe;
    logic   dropped_strobe;

    integer seed;
    int     drops_seen;
    int     served_seen;

    `include "elevator_model.svh"

    elevator_top elevator_top_i (
        .clk            (clk),
        .clear          (clear),
        .call           (call),
        .call_strobe    (call_strobe),
        .ready          (ready),
        .floor          (floor),
        .moving_up      (moving_up),
        .moving_down    (moving_down),
        .door_open      (door_open),
        .served         (served),
        .served_strobe  (served_strobe),
        .dropped_strobe (dropped_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic string stop_text(stop_t s);
        return $sformatf("{valid %0b pickup %0b kind %0d floor %0d}",
                         s.valid, s.is_pickup, s.kind, s.floor);
    endfunction

    task automatic compare_stop(string name, stop_t got, stop_t exp);
        if (got !== exp)
            report_failure($sformatf("FAIL %0t %s got %s expected %s",
                                     $time, name, stop_text(got), stop_text(exp)));
    endtask

    task automatic compare_floor(string name, floor_t got, floor_t exp);
        if (got !== exp)
            report_failure($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp)
            report_failure($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic compare_count(string name, int got, int exp);
        if (got != exp)
            report_failure($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    // every served stop must be the next one the model expects
    always @(negedge clk) begin
        stop_t want;
        if (dropped_strobe === 1'b1) drops_seen++;
        if (served_strobe === 1'b1) begin
            served_seen++;
            if (expected_q.size() == 0) begin
                report_failure("served_strobe pulsed with no stop left to serve");
            end else begin
                want = expected_q.pop_front();
                compare_stop("served", served, want);
                compare_floor("floor", floor, want.floor);  // car stands at the stop
                compare_flag("door_open", door_open, 1'b1);
            end
        end
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic call_t random_call();
        call_t c;
        c.origin      = floor_t'(rand_below(4));
        c.destination = floor_t'(rand_below(4));
        c.kind        = load_kind_t'(rand_below(4));
        return c;
    endfunction

    task automatic drive_call(call_t c);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 50) report_failure("ready stayed low, the call could not be sent");
        end while (ready !== 1'b1);
        @(posedge clk);
        call        <= c;
        call_strobe <= 1'b1;
        @(posedge clk);
        call_strobe <= 1'b0;  // taken on this edge
    endtask

    task automatic send_call(call_t c);
        drive_call(c);
        split_call(c);
    endtask

    // until the car is parked with the door shut and nothing left to serve
    task automatic wait_settled(int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) report_failure("the car did not finish its stops in time");
        end while (expected_q.size() != 0 || door_open || moving_up || moving_down || !ready);
    endtask

    task automatic pickup_at_car_floor();
        call_t c;
        int    start;
        int    n;
        c        = random_call();
        c.origin = model_car_floor;
        if (c.destination == c.origin) c.destination = c.origin + 2'd1;
        start = served_seen;
        send_call(c);
        service_order();
        n = 0;
        do begin
            @(negedge clk);
            compare_flag("moving_up", moving_up, 1'b0);
            compare_flag("moving_down", moving_down, 1'b0);
            n++;
            if (n > 50) report_failure("the pickup at the car's floor was never served");
        end while (served_seen == start);
        wait_settled(500);
    endtask

    task automatic single_trip();
        call_t c;
        c = random_call();
        if (c.destination == c.origin) c.destination = c.origin + 2'd2;
        send_call(c);
        service_order();
        wait_settled(1000);
    endtask

    task automatic empty_trips(int trips);
        call_t c;
        repeat (trips) begin
            c             = random_call();
            c.destination = c.origin;  // one drop-off only
            send_call(c);
            service_order();
            wait_settled(500);
        end
    endtask

    // all stops land before the car reaches its first new floor
    task automatic three_call_burst();
        call_t c;
        for (int k = 0; k < 3; k++) begin
            c = random_call();
            if (k == 0 && c.origin == model_car_floor) c.origin = model_car_floor + 2'd2;
            send_call(c);
        end
        service_order();
        wait_settled(2000);
    endtask

    task automatic clear_while_moving();
        call_t  c;
        floor_t from;
        int     n;
        from     = model_car_floor;
        c        = random_call();
        c.origin = from + 2'd2;
        if (c.destination == c.origin) c.destination = c.origin + 2'd1;
        send_call(c);
        service_order();
        n = 0;
        // one floor behind the car and one still ahead, never floor 0
        do begin
            @(negedge clk);
            n++;
            if (n > 50) report_failure("the car never moved off its floor");
        end while (!(moving_up || moving_down) || floor == from);
        @(posedge clk);
        clear <= 1'b1;
        expected_q.delete();
        reset_model();
        repeat (2) @(posedge clk);
        clear <= 1'b0;
        @(negedge clk);
        compare_floor("floor", floor, 2'd0);
        compare_flag("door_open", door_open, 1'b0);
        compare_flag("moving_up", moving_up, 1'b0);
        compare_flag("moving_down", moving_down, 1'b0);
        compare_flag("ready", ready, 1'b1);
        repeat (3 * MOVE_CYCLES + DOOR_CYCLES) @(negedge clk);  // any served stop fails here
    endtask

    // car starts at floor 0 and heads for floor 3 while the list fills up
    task automatic overflow_list();
        call_t c;
        int    n;
        c = '{origin: 2'd3, destination: 2'd3, kind: load_kind_t'(rand_below(4))};
        send_call(c);
        for (int k = 0; k < 9; k++) begin
            c = '{origin: 2'd3, destination: floor_t'(rand_below(3)),
                  kind: load_kind_t'(rand_below(4))};
            send_call(c);
        end
        // last pickup meets the full list and its drop-off meets the first pop
        c = '{origin: 2'd3, destination: floor_t'(rand_below(3)),
              kind: load_kind_t'(rand_below(4))};
        split_call(c);
        service_order();
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 200) report_failure("the car never opened its door on the full list");
        end while (served_strobe !== 1'b1);
        repeat (4) @(posedge clk);  // taken 6 cycles after the door opens
        drive_call(c);
        wait_settled(4000);
        compare_count("dropped_strobe count", drops_seen, model_drops);
    endtask

    initial begin
        seed        = 32'hac69_7cae;
        drops_seen  = 0;
        served_seen = 0;
        model_drops = 0;
        clear       = 1'b1;
        call        = '0;
        call_strobe = 1'b0;
        reset_model();
        repeat (4) @(posedge clk);
        clear <= 1'b0;

        pickup_at_car_floor();
        single_trip();
        empty_trips(3);
        repeat (4) three_call_burst();
        clear_while_moving();
        overflow_list();

        $display("All tests passed");
        $finish;
    end

endmodule
